/* tb.f */
src/rv_core_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/result_stage.sv
src/core_top.sv
dv/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "^Simulation passed$$" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

	localparam logic [63:0] reset_addr = 64'h0000_1000;
	localparam int imem_words  = 128; // pc[8:2] inside the window
	localparam int n_random    = 40;
	localparam int wait_cycles = 10;  // per retire

	typedef struct packed {
		logic [63:0] pc;
		logic        we;
		logic [4:0]  rd;
		logic [63:0] data;
	} retire_t;

	logic        clk, rst;
	logic [31:0] inst;
	logic [63:0] pc, retire_pc, retire_data;
	logic        retire_valid, retire_we;
	logic [4:0]  retire_rd;

	logic [31:0] imem [imem_words];
	logic [63:0] mreg [32]; // model register file
	retire_t     exp_q [$]; // expected retires in order
	int          prog_len;

	core_top #(.reset_pc(reset_addr)) u_dut (.*);

	// same-cycle memory that returns opcode 0 (a nop) outside the window
	assign inst = (pc[63:9] == reset_addr[63:9]) ? imem[pc[8:2]] : 32'h0;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ********************************************************************
	// instruction encoders
	// ********************************************************************
	function automatic logic [31:0] itype_word(int opc, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] rtype_word(int f7, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] branch_word(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] jal_word(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] lui_word(int rd, int imm20);
		return {imm20[19:0], rd[4:0], 7'h37};
	endfunction

	function automatic void append_word(logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endfunction

	// ********************************************************************
	// program image with a directed part then random arithmetic
	// ********************************************************************
	task automatic build_program();
		int br_f3 [6] = '{0, 1, 4, 5, 6, 7}; // beq bne blt bge bltu bgeu
		int nt_a [6]  = '{1, 2, 1, 2, 2, 1};  // operands that fall through
		int nt_b [6]  = '{2, 4, 2, 1, 1, 2};
		int t_a [6]   = '{2, 1, 2, 1, 1, 2};  // operands that take the branch
		int t_b [6]   = '{4, 2, 1, 2, 2, 1};
		int kind, rd, rs1, rs2;

		for (int i = 0; i < imem_words; i++)
			imem[i] = {i[24:0], 7'b0000000}; // opcode 0 with unique upper bits per word
		prog_len = 0;
		append_word(lui_word(1, 32'h12345));
		append_word(itype_word(32'h13, 0, 1, 1, 32'h678)); // bypass on x1
		append_word(itype_word(32'h13, 0, 2, 0, -5));
		append_word(rtype_word(0, 3, 1, 2));
		append_word(rtype_word(32'h20, 4, 3, 1));          // x4 = -5
		append_word(itype_word(32'h13, 0, 0, 0, 7));       // write to x0 dropped
		append_word(rtype_word(0, 5, 0, 0));               // x0 reads zero
		append_word(rtype_word(32'h20, 6, 0, 2));
		for (int k = 0; k < 6; k++) begin
			append_word(branch_word(br_f3[k], nt_a[k], nt_b[k], 8));
			append_word(branch_word(br_f3[k], t_a[k], t_b[k], 8));
			append_word(itype_word(32'h13, 0, 7, 0, 99)); // skipped
		end
		append_word(jal_word(8, 12));
		append_word(itype_word(32'h13, 0, 7, 0, 99));
		append_word(itype_word(32'h13, 0, 7, 0, 99));
		append_word(lui_word(9, int'(reset_addr[31:12])));
		// odd offset whose target lands three words ahead
		append_word(itype_word(32'h67, 0, 10, 9, (prog_len + 3) * 4 + 1));
		append_word(itype_word(32'h13, 0, 7, 0, 99));
		append_word(itype_word(32'h13, 0, 7, 0, 99));
		append_word(32'h0000_0073);                   // ecall retires as a nop
		append_word(itype_word(32'h13, 1, 11, 1, 3)); // slli retires as a nop
		append_word(branch_word(2, 0, 0, 8));         // reserved funct3
		append_word(rtype_word(0, 11, 10, 8));        // sum of both links
		append_word(jal_word(0, 8));                  // jump without a link
		append_word(itype_word(32'h13, 0, 7, 0, 99));
		for (int i = 0; i < n_random; i++) begin
			kind = $urandom_range(3, 0);
			rd   = $urandom_range(7, 0); // few regs give many dependencies
			rs1  = $urandom_range(7, 0);
			rs2  = $urandom_range(7, 0);
			case (kind)
				0:       append_word(lui_word(rd, $urandom()));
				1:       append_word(itype_word(32'h13, 0, rd, rs1, $urandom()));
				2:       append_word(rtype_word(0, rd, rs1, rs2));
				default: append_word(rtype_word(32'h20, rd, rs1, rs2));
			endcase
		end
	endtask

	// ********************************************************************
	// architectural model stepping one instruction per call
	// ********************************************************************
	task automatic model_exec(input logic [31:0] w, input logic [63:0] cur_pc,
		output logic [63:0] next_pc, output logic we, output logic [63:0] data);
		logic [63:0] a, b, imm_i, imm_u, imm_b, imm_j;
		logic        take;

		a       = mreg[w[19:15]];
		b       = mreg[w[24:20]];
		imm_i   = {{52{w[31]}}, w[31:20]};
		imm_u   = {{32{w[31]}}, w[31:12], 12'h000};
		imm_b   = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j   = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		next_pc = cur_pc + 64'd4;
		we      = 1'b0;
		data    = 64'd0;
		take    = 1'b0;
		case (w[6:0])
			7'h37: begin // lui
				we   = 1'b1;
				data = imm_u;
			end
			7'h13: if (w[14:12] == 3'd0) begin // addi only
				we   = 1'b1;
				data = a + imm_i;
			end
			7'h33: if (w[14:12] == 3'd0 && (w[31:25] == 7'h00 || w[31:25] == 7'h20)) begin
				we   = 1'b1;
				data = w[30] ? a - b : a + b;
			end
			7'h6f: begin // jal
				we      = 1'b1;
				data    = cur_pc + 64'd4;
				next_pc = cur_pc + imm_j;
			end
			7'h67: if (w[14:12] == 3'd0) begin // jalr
				we      = 1'b1;
				data    = cur_pc + 64'd4;
				next_pc = (a + imm_i) & ~64'd1;
			end
			7'h63: begin
				case (w[14:12])
					3'd0:    take = (a == b);
					3'd1:    take = (a != b);
					3'd4:    take = ($signed(a) < $signed(b));
					3'd5:    take = ($signed(a) >= $signed(b));
					3'd6:    take = (a < b);
					3'd7:    take = (a >= b);
					default: take = 1'b0; // reserved funct3 is a nop
				endcase
				if (take)
					next_pc = cur_pc + imm_b;
			end
			default: ; // outside the subset
		endcase
		if (w[11:7] == 5'd0)
			we = 1'b0; // x0 never written
		if (we)
			mreg[w[11:7]] = data;
	endtask

	// walk the image from reset_addr and record every retire
	task automatic predict_retires();
		logic [63:0] p, np, d;
		logic        w_en;
		int          steps;
		retire_t     e;

		for (int i = 0; i < 32; i++)
			mreg[i] = 64'd0;
		p     = reset_addr;
		steps = 0;
		while (p[63:9] == reset_addr[63:9] && int'(p[8:2]) < prog_len && steps < 1000) begin
			model_exec(imem[p[8:2]], p, np, w_en, d);
			e.pc   = p;
			e.we   = w_en;
			e.rd   = imem[p[8:2]][11:7];
			e.data = d;
			exp_q.push_back(e);
			p = np;
			steps++;
		end
	endtask

	// wait for the next retire within a bounded number of cycles
	task automatic wait_retire(output bit seen);
		int n;

		seen = 1'b0;
		n    = 0;
		while (!seen && n < wait_cycles) begin
			@(negedge clk); // outputs settled
			seen = retire_valid;
			n++;
		end
	endtask

	task automatic compare_field(input string name, input logic [63:0] got,
		input logic [63:0] want, inout int bad);
		assert (got === want) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			bad++;
		end
	endtask

	// ********************************************************************
	// main sequence
	// ********************************************************************
	initial begin
		int      passed, errors, bad;
		bit      seen, timed_out;
		retire_t e;

		passed    = 0;
		errors    = 0;
		timed_out = 1'b0;
		rst       = 1'b1;
		void'($urandom(32'heacc)); // single seed for the run
		build_program();
		predict_retires();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk); // pc parked and nothing retired yet
		bad = 0;
		compare_field("pc", pc, reset_addr, bad);
		compare_field("retire_valid", 64'(retire_valid), 64'd0, bad);
		$display("reset check: %s", (bad == 0) ? "ok" : "FAIL");
		errors += bad;

		for (int i = 0; i < exp_q.size() && !timed_out; i++) begin
			e = exp_q[i];
			wait_retire(seen);
			if (!seen) begin
				$display("retire of entry %0d at pc %h never came within %0d cycles",
					i, e.pc, wait_cycles);
				errors++;
				timed_out = 1'b1;
			end else begin
				bad = 0;
				compare_field("retire_pc", retire_pc, e.pc, bad);
				compare_field("retire_we", 64'(retire_we), 64'(e.we), bad);
				if (e.we) begin // rd and data only mean something on a write
					compare_field("retire_rd", 64'(retire_rd), 64'(e.rd), bad);
					compare_field("retire_data", retire_data, e.data, bad);
				end
				$display("entry %0d pc %h: %s", i, e.pc, (bad == 0) ? "ok" : "FAIL");
				if (bad == 0)
					passed++;
				errors += bad;
			end
		end

		$display("%0d of %0d entries passed, %0d errors", passed, exp_q.size(), errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* src/core_top.sv */
`timescale 1ns/1ps

module core_top import rv_core_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = 64'h8000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [ilen-1:0]       inst,
	output logic [xlen-1:0]       pc,
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	// fetch -> decode
	logic                  id_valid;
	logic [xlen-1:0]       id_pc;
	logic [ilen-1:0]       id_inst;
	// decode <-> reg file
	logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
	logic [xlen-1:0]       rs1_data, rs2_data;
	// decode -> execute
	logic                  ex_valid;
	op_e                   ex_op;
	logic [reg_addr_w-1:0] ex_rd;
	logic [xlen-1:0]       ex_rs1_val, ex_rs2_val, ex_imm, ex_pc;
	// execute -> fetch, result
	logic                  pc_update;
	logic [xlen-1:0]       dnpc;
	logic                  res_valid, res_we;
	logic [reg_addr_w-1:0] res_rd;
	logic [xlen-1:0]       res_data, res_pc;
	// writeback
	logic                  wb_we;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0]       wb_data;

	fetch_unit #(.reset_pc(reset_pc)) u_fetch (.*);
	decode_unit  u_decode  (.*);
	reg_file     u_regs    (.*);
	execute_unit u_execute (.*);
	result_stage u_result  (.*);

endmodule

/* src/result_stage.sv */
`timescale 1ns/1ps

module result_stage import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  res_valid,
	input  logic                  res_we,
	input  logic [reg_addr_w-1:0] res_rd,
	input  logic [xlen-1:0]       res_data,
	input  logic [xlen-1:0]       res_pc,
	output logic                  wb_we,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0]       wb_data,
	output logic                  retire_valid,
	output logic [xlen-1:0]       retire_pc,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	logic                  valid_q, we_q; // control
	logic [reg_addr_w-1:0] rd_q;
	logic [xlen-1:0]       data_q, pc_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			we_q    <= 1'b0;
		end else begin
			valid_q <= res_valid;
			we_q    <= res_we;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		rd_q   <= res_rd;
		data_q <= res_data;
		pc_q   <= res_pc;
	end

	// ********************************************************************
	// same flops feed the reg file and the retire report
	// ********************************************************************
	assign wb_we        = we_q;
	assign wb_rd        = rd_q;
	assign wb_data      = data_q;
	assign retire_valid = valid_q;
	assign retire_we    = we_q;
	assign retire_rd    = rd_q;
	assign retire_data  = data_q;
	assign retire_pc    = pc_q;

	// no write without a retiring instruction behind it
	a_we_has_valid: assert property (@(posedge clk) disable iff (rst)
		wb_we |-> retire_valid);

endmodule

/* src/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import rv_core_pkg::*; (
	input  logic                  ex_valid,
	input  op_e                   ex_op,
	input  logic [reg_addr_w-1:0] ex_rd,
	input  logic [xlen-1:0]       ex_rs1_val,
	input  logic [xlen-1:0]       ex_rs2_val,
	input  logic [xlen-1:0]       ex_imm,
	input  logic [xlen-1:0]       ex_pc,
	output logic                  pc_update, // strobe, taken or not
	output logic [xlen-1:0]       dnpc,
	output logic                  res_valid,
	output logic                  res_we,
	output logic [reg_addr_w-1:0] res_rd,
	output logic [xlen-1:0]       res_data,
	output logic [xlen-1:0]       res_pc
);

	logic [xlen-1:0] link;     // pc+4, also fall-through
	logic [xlen-1:0] br_target;
	logic [xlen-1:0] jalr_target;
	logic            is_ctrl;
	logic            writes;   // op writes rd
	logic            taken;

	assign link        = ex_pc + 64'd4;
	assign br_target   = ex_pc + ex_imm;
	assign jalr_target = (ex_rs1_val + ex_imm) & ~64'd1; // clear bit 0

	// ********************************************************************
	// alu, compare and next pc
	// ********************************************************************
	always_comb begin
		res_data = '0;
		writes   = 1'b0;
		is_ctrl  = 1'b0;
		taken    = 1'b0;
		dnpc     = link;
		case (ex_op)
			op_lui:  begin res_data = ex_imm;                  writes = 1'b1; end
			op_addi: begin res_data = ex_rs1_val + ex_imm;     writes = 1'b1; end
			op_add:  begin res_data = ex_rs1_val + ex_rs2_val; writes = 1'b1; end
			op_sub:  begin res_data = ex_rs1_val - ex_rs2_val; writes = 1'b1; end
			op_jal:  begin res_data = link; writes = 1'b1; is_ctrl = 1'b1; dnpc = br_target; end
			op_jalr: begin res_data = link; writes = 1'b1; is_ctrl = 1'b1; dnpc = jalr_target; end
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
				is_ctrl = 1'b1;
				case (ex_op)
					op_beq:  taken = ex_rs1_val == ex_rs2_val;
					op_bne:  taken = ex_rs1_val != ex_rs2_val;
					op_blt:  taken = $signed(ex_rs1_val) <  $signed(ex_rs2_val);
					op_bge:  taken = $signed(ex_rs1_val) >= $signed(ex_rs2_val);
					op_bltu: taken = ex_rs1_val <  ex_rs2_val;
					default: taken = ex_rs1_val >= ex_rs2_val; // bgeu
				endcase
				dnpc = taken ? br_target : link;
			end
			default: ; // nop retires without a write
		endcase
	end

	assign pc_update = ex_valid && is_ctrl;
	assign res_valid = ex_valid;
	assign res_we    = ex_valid && writes && (ex_rd != '0); // x0 writes dropped here
	assign res_rd    = ex_rd;
	assign res_pc    = ex_pc;

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] rs1_addr,
	input  logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0]       rs1_data,
	output logic [xlen-1:0]       rs2_data,
	input  logic                  wb_we,
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic [xlen-1:0]       wb_data
);

	logic [xlen-1:0] regs [2**reg_addr_w]; // x0..x31

	// single write port, x0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**reg_addr_w; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// async reads
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// x0 stays zero across any write sequence
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		(rs1_addr == '0) |-> (rs1_data == '0));

endmodule

/* src/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit import rv_core_pkg::*; (
	input  logic                  id_valid,
	input  logic [xlen-1:0]       id_pc,
	input  logic [ilen-1:0]       id_inst,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input  logic [xlen-1:0]       rs1_data,
	input  logic [xlen-1:0]       rs2_data,
	input  logic                  wb_we,   // write in flight from result stage
	input  logic [reg_addr_w-1:0] wb_rd,
	input  logic [xlen-1:0]       wb_data,
	output logic                  ex_valid,
	output op_e                   ex_op,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic [xlen-1:0]       ex_rs1_val,
	output logic [xlen-1:0]       ex_rs2_val,
	output logic [xlen-1:0]       ex_imm,
	output logic [xlen-1:0]       ex_pc
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] imm_i, imm_u, imm_j, imm_b;

	// fields
	assign opcode   = id_inst[6:0];
	assign funct3   = id_inst[14:12];
	assign funct7   = id_inst[31:25];
	assign rs1_addr = id_inst[19:15];
	assign rs2_addr = id_inst[24:20];
	assign ex_rd    = id_inst[11:7];
	assign ex_valid = id_valid;
	assign ex_pc    = id_pc;

	// ********************************************************************
	// immediates, all sign extended from inst[31]
	// ********************************************************************
	assign imm_i = {{(xlen-12){id_inst[31]}}, id_inst[31:20]};
	assign imm_u = {{(xlen-32){id_inst[31]}}, id_inst[31:12], 12'b0};
	assign imm_j = {{(xlen-20){id_inst[31]}}, id_inst[19:12], id_inst[20],
		id_inst[30:21], 1'b0};
	assign imm_b = {{(xlen-12){id_inst[31]}}, id_inst[7], id_inst[30:25],
		id_inst[11:8], 1'b0};

	// classification, op_nop if nothing matches
	always_comb begin
		ex_op  = op_nop;
		ex_imm = imm_i; // I-format covers addi and jalr
		case (opcode)
			opc_lui: begin
				ex_op  = op_lui;
				ex_imm = imm_u;
			end
			opc_op_imm: if (funct3 == 3'b000) ex_op = op_addi;
			opc_op: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000) ex_op = op_add;
				if (funct3 == 3'b000 && funct7 == 7'b0100000) ex_op = op_sub;
			end
			opc_jal: begin
				ex_op  = op_jal;
				ex_imm = imm_j;
			end
			opc_jalr: if (funct3 == 3'b000) ex_op = op_jalr;
			opc_branch: begin
				ex_imm = imm_b;
				case (funct3)
					3'b000:  ex_op = op_beq;
					3'b001:  ex_op = op_bne;
					3'b100:  ex_op = op_blt;
					3'b101:  ex_op = op_bge;
					3'b110:  ex_op = op_bltu;
					3'b111:  ex_op = op_bgeu;
					default: ex_op = op_nop; // 010/011 reserved
				endcase
			end
			default: ex_op = op_nop;
		endcase
	end

	// operand select, bypass the write that lands at the end of this cycle
	assign ex_rs1_val = (wb_we && wb_rd != '0 && wb_rd == rs1_addr) ? wb_data : rs1_data;
	assign ex_rs2_val = (wb_we && wb_rd != '0 && wb_rd == rs2_addr) ? wb_data : rs2_data;

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = 64'h8000_0000
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [ilen-1:0] inst,      // comb. from imem at pc
	input  logic            pc_update, // branch resolved in execute
	input  logic [xlen-1:0] dnpc,      // resolved next pc
	output logic [xlen-1:0] pc,
	output logic            id_valid,
	output logic [xlen-1:0] id_pc,
	output logic [ilen-1:0] id_inst
);

	fetch_state_e state;
	logic         is_ctrl; // current inst is jal/jalr/branch
	logic [2:0]   funct3;

	assign funct3 = inst[14:12];

	// ********************************************************************
	// pre-decode, one decision for all control transfers
	// ********************************************************************
	always_comb begin
		unique case (inst[6:0])
			opc_jal:    is_ctrl = 1'b1;
			opc_jalr:   is_ctrl = (funct3 == 3'b000);
			opc_branch: is_ctrl = (funct3 != 3'b010) && (funct3 != 3'b011); // 010/011 reserved
			default:    is_ctrl = 1'b0;
		endcase
	end

	// pc, state and the valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= reset_pc;
			state    <= fetch_run;
			id_valid <= 1'b0;
		end else begin
			case (state)
				fetch_run: begin
					id_valid <= 1'b1;
					if (is_ctrl)
						state <= fetch_wait_branch; // hold pc, wait for execute
					else
						pc <= pc + 64'd4;
				end
				fetch_wait_branch: begin
					id_valid <= 1'b0; // bubble
					if (pc_update) begin
						pc    <= dnpc;
						state <= fetch_run;
					end
				end
				default: state <= fetch_run;
			endcase
		end
	end

	// fetch-to-decode payload, qualified by id_valid
	always_ff @(posedge clk) begin
		if (state == fetch_run) begin
			id_pc   <= pc;
			id_inst <= inst;
		end
	end

	// execute only resolves what fetch is waiting on
	a_update_only_in_wait: assert property (@(posedge clk) disable iff (rst)
		pc_update |-> state == fetch_wait_branch);

endmodule

/* src/rv_core_pkg.sv */
package rv_core_pkg;

	// ********************************************************************
	// widths
	// ********************************************************************
	localparam int xlen       = 64; // data and address width
	localparam int ilen       = 32; // instruction word
	localparam int reg_addr_w = 5;  // x0..x31

	// decoded operations, shared by decode and execute
	typedef enum logic [3:0] {
		op_lui,
		op_addi,
		op_add,
		op_sub,
		op_jal,
		op_jalr,
		op_beq,
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_nop // anything outside the subset
	} op_e;

	// fetch fsm
	typedef enum logic {
		fetch_run,         // issuing one inst per cycle
		fetch_wait_branch  // pc frozen until execute resolves
	} fetch_state_e;

	// ********************************************************************
	// major opcode field, inst[6:0]
	// ********************************************************************
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;

endpackage
